// File: hdl/drp_pkg.sv
`default_nettype none

package drp_pkg;

  parameter int DRP_AW = 5;
  parameter int DRP_DW = 16;

  // ************************************************************
  // Divider register addresses
  // ************************************************************
  localparam logic [DRP_AW-1:0] ADDR_CLKOUT0_R1 = 5'h08;
  localparam logic [DRP_AW-1:0] ADDR_CLKOUT0_R2 = 5'h09;
  localparam logic [DRP_AW-1:0] ADDR_CLKFB_R1   = 5'h14;
  localparam logic [DRP_AW-1:0] ADDR_CLKFB_R2   = 5'h15;

  // Same 16-bit word, decoded as register 1 or register 2
  typedef union packed {
    struct packed {
      logic [2:0] phase_mux;
      logic       rsvd;
      logic [5:0] high_time;
      logic [5:0] low_time;
    } r1;
    struct packed {
      logic [7:0] rsvd;
      logic       edge_flag;  // Odd count
      logic       no_count;   // Bypass for count of 1
      logic [5:0] delay_time;
    } r2;
  } div_reg_u;

  localparam logic [DRP_DW-1:0] KEEP_R1 = 16'hF000;  // Phase mux and reserved bit
  localparam logic [DRP_DW-1:0] KEEP_R2 = 16'hFF00;  // Upper byte

endpackage

`default_nettype wire

// File: hdl/clk_profile_pkg.sv
`default_nettype none

package clk_profile_pkg;

  parameter int NUM_PROFILES = 4;

  // CLKOUT0 divide and CLKFBOUT multiply, indexed by profile
  localparam logic [7:0] PROF_D [NUM_PROFILES] = '{8'd20, 8'd10, 8'd8, 8'd5};
  localparam logic [7:0] PROF_M [NUM_PROFILES] = '{8'd40, 8'd20, 8'd32, 8'd25};

  function automatic logic [7:0] prof_div_d(input int unsigned p);
    return PROF_D[p % NUM_PROFILES];
  endfunction

  function automatic logic [7:0] prof_mult_m(input int unsigned p);
    return PROF_M[p % NUM_PROFILES];
  endfunction

  // Returns {high_time, low_time}
  function automatic logic [11:0] div_r1_bits(input logic [7:0] n);
    logic [7:0] hi;
    logic [7:0] lo;
    hi = n >> 1;
    lo = n - hi;  // Extra half cycle goes to low time
    return {hi[5:0], lo[5:0]};
  endfunction

  // Returns {edge_flag, no_count, delay_time}
  function automatic logic [7:0] div_r2_bits(input logic [7:0] n);
    logic edge_f;
    logic nocnt;
    edge_f = n[0];
    nocnt  = (n == 8'd1);
    return {edge_f, nocnt, 6'd0};
  endfunction

endpackage

`default_nettype wire

// File: hdl/cfg_cmd_capture.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_cmd_capture #(
  parameter int PROF_W = 2
) (
  input  wire logic              CLKS,
  input  wire logic              RSTXS,
  input  wire logic              cfg_req,
  input  wire logic [PROF_W-1:0] cfg_prof,
  input  wire logic              clk_ready,
  output logic                   cfg_ack,
  output logic                   prof_req,
  output logic      [PROF_W-1:0] prof
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_BUSY = 2'd1;
  localparam logic [1:0] S_ACK  = 2'd2;

  logic [1:0] state;
  logic       req_d;

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      state <= S_IDLE;
      req_d <= 1'b0;
    end else begin
      req_d <= cfg_req;
      case (state)
        S_IDLE:  if (cfg_req && !req_d) state <= S_BUSY;  // New request only on rising req
        S_BUSY:  if (clk_ready) state <= S_ACK;
        S_ACK:   if (!cfg_req) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Profile held for the whole command
  always_ff @(posedge CLKS) begin
    if (state == S_IDLE && cfg_req && !req_d) prof <= cfg_prof;
  end

  assign prof_req = (state == S_BUSY);
  assign cfg_ack  = (state == S_ACK);

endmodule

`default_nettype wire

// File: hdl/profile_step_gen.sv
`timescale 1ns/1ps
`default_nettype none

module profile_step_gen
  import drp_pkg::*;
  import clk_profile_pkg::*;
#(
  parameter int PROF_W = 2
) (
  input  wire logic              CLKS,
  input  wire logic              RSTXS,
  input  wire logic              prof_req,
  input  wire logic [PROF_W-1:0] prof,
  input  wire logic              step_ack,
  output logic                   step_req,
  output logic      [DRP_AW-1:0] step_addr,
  output logic      [DRP_DW-1:0] step_keep,
  output logic      [DRP_DW-1:0] step_bits,
  output logic                   steps_done
);

  logic              prof_req_d;
  logic              active;
  logic [2:0]        gen_cnt;   // Steps expanded so far
  logic [1:0]        ack_cnt;
  logic              buf_valid;
  logic [DRP_AW-1:0] buf_addr;
  logic [DRP_DW-1:0] buf_keep;
  logic [DRP_DW-1:0] buf_bits;
  logic [DRP_AW-1:0] nxt_addr;
  logic [DRP_DW-1:0] nxt_keep;
  div_reg_u          nxt_word;
  logic [7:0]        count;
  logic              start;
  logic              load;
  logic              fill;

  // ************************************************************
  // Step expansion
  // ************************************************************
  always_comb begin
    count    = gen_cnt[1] ? prof_mult_m(32'(prof)) : prof_div_d(32'(prof));
    nxt_word = '0;
    if (!gen_cnt[0]) begin
      {nxt_word.r1.high_time, nxt_word.r1.low_time} = div_r1_bits(count);
      nxt_keep = KEEP_R1;
    end else begin
      {nxt_word.r2.edge_flag, nxt_word.r2.no_count, nxt_word.r2.delay_time} = div_r2_bits(count);
      nxt_keep = KEEP_R2;
    end
    case (gen_cnt[1:0])
      2'd0:    nxt_addr = ADDR_CLKOUT0_R1;
      2'd1:    nxt_addr = ADDR_CLKOUT0_R2;
      2'd2:    nxt_addr = ADDR_CLKFB_R1;
      default: nxt_addr = ADDR_CLKFB_R2;
    endcase
  end

  assign start = prof_req & ~prof_req_d;
  assign load  = buf_valid & ~step_req & ~step_ack;  // Previous handshake fully closed
  assign fill  = active & (gen_cnt != 3'd4) & (~buf_valid | load);

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      prof_req_d <= 1'b0;
      active     <= 1'b0;
      gen_cnt    <= 3'd0;
      ack_cnt    <= 2'd0;
      buf_valid  <= 1'b0;
      step_req   <= 1'b0;
      steps_done <= 1'b0;
    end else begin
      prof_req_d <= prof_req;
      steps_done <= 1'b0;
      if (start) begin
        active    <= 1'b1;
        gen_cnt   <= 3'd0;
        ack_cnt   <= 2'd0;
        buf_valid <= 1'b0;
      end else begin
        if (fill) gen_cnt <= gen_cnt + 3'd1;
        if (fill) buf_valid <= 1'b1;
        else if (load) buf_valid <= 1'b0;
        if (load) step_req <= 1'b1;
        if (step_req && step_ack) begin
          step_req <= 1'b0;
          ack_cnt  <= ack_cnt + 2'd1;
          if (ack_cnt == 2'd3) begin  // Fourth write done
            steps_done <= 1'b1;
            active     <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge CLKS) begin
    if (fill) begin
      buf_addr <= nxt_addr;
      buf_keep <= nxt_keep;
      buf_bits <= nxt_word;
    end
    if (load) begin
      step_addr <= buf_addr;
      step_keep <= buf_keep;
      step_bits <= buf_bits;
    end
  end

endmodule

`default_nettype wire

// File: hdl/drp_rmw_engine.sv
`timescale 1ns/1ps
`default_nettype none

module drp_rmw_engine
  import drp_pkg::*;
(
  input  wire logic              CLKS,
  input  wire logic              RSTXS,
  input  wire logic              step_req,
  input  wire logic [DRP_AW-1:0] step_addr,
  input  wire logic [DRP_DW-1:0] step_keep,
  input  wire logic [DRP_DW-1:0] step_bits,
  input  wire logic [DRP_DW-1:0] drp_do,
  input  wire logic              drp_drdy,
  output logic                   step_ack,
  output logic                   drp_den,
  output logic                   drp_dwe,
  output logic      [DRP_AW-1:0] drp_addr,
  output logic      [DRP_DW-1:0] drp_di
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_READ    = 3'd1;
  localparam logic [2:0] S_WAIT_RD = 3'd2;
  localparam logic [2:0] S_WRITE   = 3'd3;
  localparam logic [2:0] S_WAIT_WR = 3'd4;
  localparam logic [2:0] S_ACK     = 3'd5;

  logic [2:0]        state;
  logic [DRP_AW-1:0] addr_q;
  logic [DRP_DW-1:0] data_q;

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:    if (step_req) state <= S_READ;
        S_READ:    state <= S_WAIT_RD;
        S_WAIT_RD: if (drp_drdy) state <= S_WRITE;
        S_WRITE:   state <= S_WAIT_WR;
        S_WAIT_WR: if (drp_drdy) state <= S_ACK;
        S_ACK:     if (!step_req) state <= S_IDLE;  // Four-phase close
        default:   state <= S_IDLE;
      endcase
    end
  end

  // ************************************************************
  // Address and merge register
  // ************************************************************
  always_ff @(posedge CLKS) begin
    if (state == S_IDLE && step_req) addr_q <= step_addr;
    if (state == S_WAIT_RD && drp_drdy) begin
      data_q <= (drp_do & step_keep) | step_bits;  // Untouched fields survive
    end
  end

  // One-cycle strobes from the single-cycle states
  assign drp_den  = (state == S_READ) | (state == S_WRITE);
  assign drp_dwe  = (state == S_WRITE);
  assign drp_addr = addr_q;
  assign drp_di   = data_q;
  assign step_ack = (state == S_ACK);

endmodule

`default_nettype wire

// File: hdl/pll_reset_seq.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reset_seq #(
  parameter int RST_HOLD  = 8,
  parameter int LOCK_SYNC = 2
) (
  input  wire logic CLKS,
  input  wire logic RSTXS,
  input  wire logic prof_req,
  input  wire logic steps_done,
  input  wire logic pll_locked,
  output logic      pll_rst,
  output logic      clk_ready
);

  localparam int CNT_W = $clog2(RST_HOLD + 1);

  logic                 prof_req_d;
  logic                 start;
  logic                 hold;
  logic [CNT_W-1:0]     hold_cnt;
  logic                 armed;      // Update finished and reset released
  logic [LOCK_SYNC-1:0] lock_sync;

  assign start = prof_req & ~prof_req_d;

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      prof_req_d <= 1'b0;
      pll_rst    <= 1'b0;
      hold       <= 1'b0;
      hold_cnt   <= '0;
      armed      <= 1'b0;
    end else begin
      prof_req_d <= prof_req;
      if (start) begin
        pll_rst <= 1'b1;
        armed   <= 1'b0;
        hold    <= 1'b0;
      end else if (steps_done) begin
        hold     <= 1'b1;
        hold_cnt <= CNT_W'(RST_HOLD - 1);
      end else if (hold) begin
        if (hold_cnt <= CNT_W'(1)) begin  // Reset released RST_HOLD cycles after done
          hold    <= 1'b0;
          pll_rst <= 1'b0;
          armed   <= 1'b1;
        end else begin
          hold_cnt <= hold_cnt - CNT_W'(1);
        end
      end
    end
  end

  // ************************************************************
  // Lock synchronizer, only counts lock with reset low
  // ************************************************************
  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      lock_sync <= '0;
    end else begin
      lock_sync[0] <= pll_locked & ~pll_rst;
      for (int i = 1; i < LOCK_SYNC; i++) begin
        lock_sync[i] <= lock_sync[i-1];
      end
    end
  end

  assign clk_ready = armed & lock_sync[LOCK_SYNC-1] & ~start;  // Drops as a command starts

endmodule

`default_nettype wire

// File: hdl/clk_reconfig_top.sv
`timescale 1ns/1ps
`default_nettype none

module clk_reconfig_top
  import drp_pkg::*;
#(
  parameter int PROF_W    = 2,
  parameter int RST_HOLD  = 8,
  parameter int LOCK_SYNC = 2
) (
  input  wire logic              CLKS,
  input  wire logic              RSTXS,
  // Host
  input  wire logic              cfg_req,
  input  wire logic [PROF_W-1:0] cfg_prof,
  output logic                   cfg_ack,
  // DRP
  output logic                   drp_den,
  output logic                   drp_dwe,
  output logic      [DRP_AW-1:0] drp_addr,
  output logic      [DRP_DW-1:0] drp_di,
  input  wire logic [DRP_DW-1:0] drp_do,
  input  wire logic              drp_drdy,
  // PLL control
  output logic                   pll_rst,
  input  wire logic              pll_locked,
  output logic                   clk_ready
);

  logic              prof_req;
  logic [PROF_W-1:0] prof;
  logic              step_req;
  logic              step_ack;
  logic [DRP_AW-1:0] step_addr;
  logic [DRP_DW-1:0] step_keep;
  logic [DRP_DW-1:0] step_bits;
  logic              steps_done;

  cfg_cmd_capture #(.PROF_W(PROF_W)) i_capture (
    .CLKS      (CLKS),
    .RSTXS     (RSTXS),
    .cfg_req   (cfg_req),
    .cfg_prof  (cfg_prof),
    .clk_ready (clk_ready),
    .cfg_ack   (cfg_ack),
    .prof_req  (prof_req),
    .prof      (prof)
  );

  profile_step_gen #(.PROF_W(PROF_W)) i_step_gen (
    .CLKS       (CLKS),
    .RSTXS      (RSTXS),
    .prof_req   (prof_req),
    .prof       (prof),
    .step_ack   (step_ack),
    .step_req   (step_req),
    .step_addr  (step_addr),
    .step_keep  (step_keep),
    .step_bits  (step_bits),
    .steps_done (steps_done)
  );

  drp_rmw_engine i_engine (
    .CLKS      (CLKS),
    .RSTXS     (RSTXS),
    .step_req  (step_req),
    .step_addr (step_addr),
    .step_keep (step_keep),
    .step_bits (step_bits),
    .drp_do    (drp_do),
    .drp_drdy  (drp_drdy),
    .step_ack  (step_ack),
    .drp_den   (drp_den),
    .drp_dwe   (drp_dwe),
    .drp_addr  (drp_addr),
    .drp_di    (drp_di)
  );

  pll_reset_seq #(.RST_HOLD(RST_HOLD), .LOCK_SYNC(LOCK_SYNC)) i_rst_seq (
    .CLKS       (CLKS),
    .RSTXS      (RSTXS),
    .prof_req   (prof_req),
    .steps_done (steps_done),
    .pll_locked (pll_locked),
    .pll_rst    (pll_rst),
    .clk_ready  (clk_ready)
  );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD = 4,  // 8 ns clock
  parameter int RST_CYCLES  = 3
) (
  output logic CLKS,
  output logic RSTXS
);

  initial begin
    CLKS = 1'b0;
    forever #(HALF_PERIOD) CLKS = ~CLKS;
  end

  initial begin
    RSTXS = 1'b0;
    repeat (RST_CYCLES) @(posedge CLKS);
    #1;
    RSTXS = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/pll_drp_model.sv
`timescale 1ns/1ps
`default_nettype none

module pll_drp_model (
  input  wire logic        CLKS,
  input  wire logic        drp_den,
  input  wire logic        drp_dwe,
  input  wire logic [4:0]  drp_addr,
  input  wire logic [15:0] drp_di,
  input  wire logic        pll_rst,
  output logic      [15:0] drp_do,
  output logic             drp_drdy,
  output logic             pll_locked
);

  logic [15:0] regs [32];
  int          seed;
  logic [31:0] rnd;
  logic        busy;
  int          lat_cnt;
  logic        acc_we;
  logic [4:0]  acc_addr;
  logic [15:0] acc_data;
  logic        rst_q;
  int          lock_cnt;

  initial begin
    seed = 49358;
    for (int i = 0; i < 32; i++) begin
      rnd     = $random(seed);
      regs[i] = rnd[15:0];  // Random reserved and phase bits to preserve
    end
    busy       = 1'b0;
    lat_cnt    = 0;
    rst_q      = 1'b0;
    lock_cnt   = 0;
    drp_do     = 16'h0000;
    drp_drdy   = 1'b0;
    pll_locked = 1'b1;
  end

  always @(posedge CLKS) begin
    logic        den_s;
    logic        we_s;
    logic [4:0]  addr_s;
    logic [15:0] di_s;
    logic        rst_s;
    den_s  = drp_den;
    we_s   = drp_dwe;
    addr_s = drp_addr;
    di_s   = drp_di;
    rst_s  = pll_rst;
    #1;
    drp_drdy = 1'b0;
    if (den_s && !busy) begin
      busy     = 1'b1;
      acc_we   = we_s;
      acc_addr = addr_s;
      acc_data = di_s;
      rnd      = $random(seed);
      lat_cnt  = 1 + (rnd % 6);  // drdy 1 to 6 cycles later
    end
    if (busy) begin
      lat_cnt = lat_cnt - 1;
      if (lat_cnt == 0) begin
        busy     = 1'b0;
        drp_drdy = 1'b1;
        if (acc_we) regs[acc_addr] = acc_data;
        else drp_do = regs[acc_addr];
      end
    end

    // ************************************************************
    // Lock behavior
    // ************************************************************
    if (rst_s) begin
      pll_locked = 1'b0;
      lock_cnt   = 0;
    end else if (rst_q) begin
      rnd      = $random(seed);
      lock_cnt = 5 + (rnd % 16);  // Reset just released
    end else if (lock_cnt > 0) begin
      lock_cnt = lock_cnt - 1;
      if (lock_cnt == 0) pll_locked = 1'b1;
    end
    rst_q = rst_s;
  end

endmodule

`default_nettype wire

// File: test/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input wire logic        CLKS,
  input wire logic        RSTXS,
  input wire logic        cfg_req,
  input wire logic [1:0]  cfg_prof,
  input wire logic        cfg_ack,
  input wire logic        drp_den,
  input wire logic        drp_dwe,
  input wire logic [4:0]  drp_addr,
  input wire logic [15:0] drp_di,
  input wire logic [15:0] drp_do,
  input wire logic        drp_drdy,
  input wire logic        pll_rst,
  input wire logic        pll_locked,
  input wire logic        clk_ready
);

  localparam int PH_READ    = 0;
  localparam int PH_WAIT_RD = 1;
  localparam int PH_WRITE   = 2;
  localparam int PH_WAIT_WR = 3;

  int          err_count;
  int          test_base;
  int          tests_run;
  int          tests_failed;
  string       cur_test;
  logic        cmd_active;
  logic [1:0]  cmd_prof;
  int          wr_idx;     // Register steps finished in this command
  int          phase;
  logic [15:0] rd_data;
  logic        lock_seen;
  logic        req_q;
  logic        ack_q;

  initial begin
    err_count    = 0;
    test_base    = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "startup";
    cmd_active   = 1'b0;
    wr_idx       = 0;
    phase        = PH_READ;
    lock_seen    = 1'b0;
    req_q        = 1'b0;
    ack_q        = 1'b0;
  end

  // ************************************************************
  // Expected register contents
  // ************************************************************
  // Output divide for steps 0 and 1, feedback multiply for 2 and 3
  function automatic logic [7:0] div_count(input logic [1:0] p, input int idx);
    case (p)
      2'd0:    return (idx < 2) ? 8'd20 : 8'd40;
      2'd1:    return (idx < 2) ? 8'd10 : 8'd20;
      2'd2:    return (idx < 2) ? 8'd8 : 8'd32;
      default: return (idx < 2) ? 8'd5 : 8'd25;
    endcase
  endfunction

  function automatic logic [4:0] reg_address(input int idx);
    case (idx)
      0:       return 5'h08;
      1:       return 5'h09;
      2:       return 5'h14;
      default: return 5'h15;
    endcase
  endfunction

  function automatic logic [15:0] expected_write(input logic [1:0] p, input int idx,
                                                 input logic [15:0] rd);
    logic [7:0] n;
    logic [7:0] high;
    logic [7:0] low;
    logic       odd;
    logic       bypass;
    n = div_count(p, idx);
    if (idx % 2 == 0) begin
      high = n / 8'd2;
      low  = n - high;
      return (rd & 16'hF000) | {4'h0, high[5:0], low[5:0]};
    end
    odd    = n[0];
    bypass = (n == 8'd1);
    return (rd & 16'hFF00) | {8'h00, odd, bypass, 6'd0};
  endfunction

  task automatic report_value(input string what, input logic [15:0] exp,
                              input logic [15:0] act);
    $display("CHECK FAILED %s: %s expected 0x%04h actual 0x%04h", cur_test, what, exp, act);
    err_count++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR in %s: %s", cur_test, what);
    err_count++;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_base = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count == test_base) begin
      $display("PASS %s", cur_test);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", cur_test, err_count - test_base);
    end
  endtask

  task automatic print_summary();
    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
  endtask

  always @(posedge CLKS) begin
    if (!RSTXS) begin
      if (cfg_ack || drp_den || pll_rst || clk_ready) begin
        report_error("cfg_ack, drp_den, pll_rst or clk_ready not low during reset");
      end
      cmd_active = 1'b0;
      req_q      = 1'b0;
      ack_q      = 1'b0;
    end else begin
      if (clk_ready && pll_rst) report_error("clk_ready high while pll_rst is high");
      if (cmd_active && !lock_seen && clk_ready) report_error("clk_ready high before lock");
      if (cmd_active && wr_idx == 4 && pll_locked && !pll_rst) lock_seen = 1'b1;

      // Host handshake
      if (cfg_ack && !clk_ready) report_error("cfg_ack high with clk_ready low");
      if (ack_q && req_q && !cfg_ack) report_error("cfg_ack fell while cfg_req was high");
      if (ack_q && !req_q && cfg_ack) report_error("cfg_ack stayed high after cfg_req fell");
      if (cfg_ack && !ack_q) begin
        if (!cmd_active) report_error("cfg_ack rose without an active command");
        else if (wr_idx != 4) report_value("write count", 16'd4, 16'(wr_idx));
        cmd_active = 1'b0;
      end
      if (cfg_req && !req_q && !cfg_ack) begin  // New command
        cmd_active = 1'b1;
        cmd_prof   = cfg_prof;
        wr_idx     = 0;
        phase      = PH_READ;
        lock_seen  = 1'b0;
      end

      // ************************************************************
      // DRP order and merged data
      // ************************************************************
      if (drp_den) begin
        if (!pll_rst) report_error("DRP access while pll_rst is low");
        if (!cmd_active || wr_idx >= 4) begin
          report_error("DRP access outside a command");
        end else if (phase == PH_READ && !drp_dwe) begin
          if (drp_addr != reg_address(wr_idx)) begin
            report_value("read address", 16'(reg_address(wr_idx)), 16'(drp_addr));
          end
          phase = PH_WAIT_RD;
        end else if (phase == PH_WRITE && drp_dwe) begin
          if (drp_addr != reg_address(wr_idx)) begin
            report_value("write address", 16'(reg_address(wr_idx)), 16'(drp_addr));
          end
          if (drp_di != expected_write(cmd_prof, wr_idx, rd_data)) begin
            report_value("write data", expected_write(cmd_prof, wr_idx, rd_data), drp_di);
          end
          phase = PH_WAIT_WR;
        end else begin
          report_error("DRP access out of order, a write must follow a read of its address");
        end
      end
      if (drp_drdy && cmd_active) begin
        if (phase == PH_WAIT_RD) begin
          rd_data = drp_do;
          phase   = PH_WRITE;
        end else if (phase == PH_WAIT_WR) begin
          wr_idx = wr_idx + 1;
          phase  = PH_READ;
        end
      end
      req_q = cfg_req;
      ack_q = cfg_ack;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  // About 120 cycles per command at worst
  localparam int CMD_BUDGET     = 12;
  localparam int CYCLES_PER_CMD = 400;
  localparam int MAX_CYCLES     = CMD_BUDGET * CYCLES_PER_CMD;

  logic        CLKS;
  logic        RSTXS;
  logic        por_rstxs;
  logic        test_rstxs;
  logic        cfg_req;
  logic [1:0]  cfg_prof;
  logic        cfg_ack;
  logic        drp_den;
  logic        drp_dwe;
  logic [4:0]  drp_addr;
  logic [15:0] drp_di;
  logic [15:0] drp_do;
  logic        drp_drdy;
  logic        pll_rst;
  logic        pll_locked;
  logic        clk_ready;
  int          cycle_cnt;

  assign RSTXS = por_rstxs & test_rstxs;

  tb_clk_gen i_clk_gen (
    .CLKS  (CLKS),
    .RSTXS (por_rstxs)
  );

  clk_reconfig_top #(.PROF_W(2), .RST_HOLD(8), .LOCK_SYNC(2)) dut (
    .CLKS       (CLKS),
    .RSTXS      (RSTXS),
    .cfg_req    (cfg_req),
    .cfg_prof   (cfg_prof),
    .cfg_ack    (cfg_ack),
    .drp_den    (drp_den),
    .drp_dwe    (drp_dwe),
    .drp_addr   (drp_addr),
    .drp_di     (drp_di),
    .drp_do     (drp_do),
    .drp_drdy   (drp_drdy),
    .pll_rst    (pll_rst),
    .pll_locked (pll_locked),
    .clk_ready  (clk_ready)
  );

  pll_drp_model i_pll (
    .CLKS       (CLKS),
    .drp_den    (drp_den),
    .drp_dwe    (drp_dwe),
    .drp_addr   (drp_addr),
    .drp_di     (drp_di),
    .pll_rst    (pll_rst),
    .drp_do     (drp_do),
    .drp_drdy   (drp_drdy),
    .pll_locked (pll_locked)
  );

  tb_checker i_checker (
    .CLKS       (CLKS),
    .RSTXS      (RSTXS),
    .cfg_req    (cfg_req),
    .cfg_prof   (cfg_prof),
    .cfg_ack    (cfg_ack),
    .drp_den    (drp_den),
    .drp_dwe    (drp_dwe),
    .drp_addr   (drp_addr),
    .drp_di     (drp_di),
    .drp_do     (drp_do),
    .drp_drdy   (drp_drdy),
    .pll_rst    (pll_rst),
    .pll_locked (pll_locked),
    .clk_ready  (clk_ready)
  );

  task automatic wait_ack(input logic level);
    do begin
      @(posedge CLKS);
    end while (cfg_ack !== level);
  endtask

  // Full four-phase command from req rise to ack fall
  task automatic run_command(input string name, input logic [1:0] p);
    i_checker.begin_test(name);
    @(posedge CLKS);
    #1;
    cfg_prof = p;
    cfg_req  = 1'b1;
    wait_ack(1'b1);
    #1;
    cfg_req = 1'b0;
    wait_ack(1'b0);
    #1;
    i_checker.end_test();
  endtask

  initial begin
    int          seed;
    logic [31:0] rnd;
    cfg_req    = 1'b0;
    cfg_prof   = 2'd0;
    test_rstxs = 1'b1;
    seed       = 49358;
    @(posedge por_rstxs);
    repeat (2) @(posedge CLKS);

    for (int p = 0; p < 4; p++) begin
      run_command($sformatf("profile_%0d", p), 2'(p));
    end

    // ************************************************************
    // Request held through ack, then re-raised without waiting
    // ************************************************************
    i_checker.begin_test("held_request");
    @(posedge CLKS);
    #1;
    cfg_prof = 2'd1;
    cfg_req  = 1'b1;
    wait_ack(1'b1);
    #1;
    cfg_prof = 2'd2;  // Must not start a command while ack is high
    repeat (20) @(posedge CLKS);
    #1;
    cfg_req = 1'b0;
    @(posedge CLKS);
    #1;
    cfg_req = 1'b1;
    wait_ack(1'b1);
    #1;
    cfg_req = 1'b0;
    wait_ack(1'b0);
    #1;
    i_checker.end_test();

    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      run_command($sformatf("random_%0d", i), rnd[1:0]);
    end

    // Reset during the first write of a command
    i_checker.begin_test("reset_mid_command");
    @(posedge CLKS);
    #1;
    cfg_prof = 2'd3;
    cfg_req  = 1'b1;
    do begin
      @(posedge CLKS);
    end while (!(drp_den && drp_dwe));
    #1;
    test_rstxs = 1'b0;
    cfg_req    = 1'b0;
    repeat (3) @(posedge CLKS);
    #1;
    test_rstxs = 1'b1;
    repeat (4) @(posedge CLKS);
    #1;
    i_checker.end_test();
    run_command("after_reset", 2'd2);

    i_checker.print_summary();
    if (i_checker.err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial cycle_cnt = 0;

  always @(posedge CLKS) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the commands did not complete", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: clk_reconfig_top.f
hdl/drp_pkg.sv
hdl/clk_profile_pkg.sv
hdl/cfg_cmd_capture.sv
hdl/profile_step_gen.sv
hdl/drp_rmw_engine.sv
hdl/pll_reset_seq.sv
hdl/clk_reconfig_top.sv
test/tb_clk_gen.sv
test/pll_drp_model.sv
test/tb_checker.sv
test/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the clock reconfiguration testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top \
  -f clk_reconfig_top.f -o sim_tb
./obj_dir/sim_tb > "$LOG" 2>&1
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation reported errors, see $LOG"
  exit 1
fi
echo "Simulation clean"
